// ==== common/rv_isa_pkg.sv ====
/*
 * RV32I architectural constants
 *
 * Data and address width, the shift amount width, the program
 * counter value loaded on reset and the small index types shared
 * by the decode and execute stages.
 */

package rv_isa_pkg;

        // ==============================
        // widths
        // ==============================

        // data and address width
        localparam int xlen = 32;

        // shifts only look at the low bits of operand two
        localparam int shamt_w = 5;

        // ==============================
        // reset values
        // ==============================

        // first fetch address after reset or flush
        localparam logic [xlen-1:0] pc_rst = 32'h8000_0000;

        // ==============================
        // types
        // ==============================

        // one machine word
        typedef logic [xlen-1:0] word_t;

        // general purpose register index, x0 to x31
        typedef logic [4:0] reg_idx_t;

        // csr read selector, picks one of the csrs the core implements
        typedef logic [1:0] csr_sel_t;

endpackage

// ==== common/pipe_ctrl_pkg.sv ====
/*
 * Pipeline control and data bundles
 *
 * Packed structs that carry one decoded instruction into execute,
 * and the execute result and redirect request towards the memory,
 * write-back and fetch stages.
 */

package pipe_ctrl_pkg;

        import rv_isa_pkg::*;

        // ==============================
        // control groups
        // ==============================

        // one-hot alu operation and operand choice
        typedef struct packed {
                logic op_add;
                logic op_sub;
                logic op_slt;
                logic op_sltu;
                logic op_or;
                logic op_and;
                logic op_xor;
                logic op_sll;
                logic op_srl;
                logic op_sra;
                logic explicit;
                logic i1_rs1;
                logic i1_pc;
                logic i2_rs2;
                logic i2_imm;
                logic i2_4;
                logic i2_csr;
        } alu_ctrl_t;

        // jump kind, target source and branch compare
        typedef struct packed {
                logic jump;
                logic pc_plus_imm;
                logic rs1_plus_imm;
                logic csr_plus_imm;
                logic cmp_eq;
                logic cmp_neq;
                logic cmp_ge;
                logic cmp_lt;
        } jump_ctrl_t;

        typedef struct packed {
                logic write_gpr;
                logic write_csr;
                logic mem_to_reg;
                logic csrrs;
                logic csrrw;
                logic ecall;
        } wb_ctrl_t;

        // store enable and access size
        typedef struct packed {
                logic write_mem;
                logic mem_byte;
                logic mem_half;
                logic mem_word;
                logic mem_byte_u;
                logic mem_half_u;
        } mem_ctrl_t;

        // ==============================
        // stage bundles
        // ==============================

        typedef struct packed {
                word_t      pc;
                reg_idx_t   rd;
                reg_idx_t   rs1;
                reg_idx_t   rs2;
                word_t      imm;
                word_t      rs1_data;
                word_t      rs2_data;
                csr_sel_t   csr_rd;
                word_t      csr_rs_data;
                alu_ctrl_t  alu_ctrl;
                jump_ctrl_t jump_ctrl;
                wb_ctrl_t   wb_ctrl;
                mem_ctrl_t  mem_ctrl;
                logic       system_halt;
                logic       op_valid;
        } id_ex_bundle_t;

        typedef struct packed {
                logic       op_valid;
                word_t      pc;
                reg_idx_t   rd;
                word_t      wb_data;
                logic       write_gpr;
                logic       write_csr;
                word_t      csr_wdata;
                logic       mem_to_reg;
                word_t      mem_addr;
                word_t      store_data;
                mem_ctrl_t  mem_ctrl;
                logic       ecall;
                logic       halt;
        } ex_result_t;

        typedef struct packed {
                logic       taken;
                word_t      target;
        } redirect_t;

        // bubble loaded on reset and flush
        localparam id_ex_bundle_t id_ex_clear = '{pc: pc_rst, default: '0};

endpackage

// ==== src/id_ex_seg_reg.sv ====
/*
 * Decode to execute segment register
 *
 * Holds one decoded instruction. Loads on a valid/ready transfer
 * that the forwarding stall does not block, and drops to a bubble
 * on reset or on a flush that arrives without a stall.
 */

`timescale 1ns/1ps

module id_ex_seg_reg (
        input  logic                          clk,
        input  logic                          rst,
        input  logic                          in_valid,
        input  logic                          exu_ready,
        input  logic                          flush,
        input  logic                          stall,
        input  pipe_ctrl_pkg::id_ex_bundle_t  in_bundle,
        output pipe_ctrl_pkg::id_ex_bundle_t  ex_bundle
);

        import pipe_ctrl_pkg::*;

        logic xfer;
        logic flush_now;

        // ==============================
        // handshake
        // ==============================

        // decode offers, execute accepts, no pending operand hazard
        assign xfer = in_valid & exu_ready & ~stall;

        // a stalled flush waits until the stall drops
        assign flush_now = flush & ~stall;

        // ==============================
        // register
        // ==============================

        always_ff @(posedge clk) begin
                if (rst || flush_now) begin
                        ex_bundle <= id_ex_clear;
                end else if (xfer) begin
                        ex_bundle <= in_bundle;
                end
        end

        // ==============================
        // checks
        // ==============================

        // the branch logic must not lose a redirect to a stall
        property p_stalled_flush_holds;
                @(posedge clk) disable iff (rst)
                (flush && stall) |=> $stable(ex_bundle);
        endproperty

        a_stalled_flush_holds : assert property (p_stalled_flush_holds)
                else $error("flush acted on while stall was high");

endmodule

// ==== execute/alu_unit.sv ====
/*
 * Integer ALU
 *
 * Chooses the two operands from the registered bundle and applies
 * the one operation whose strobe is set. No strobe gives zero.
 */

`timescale 1ns/1ps

module alu_unit (
        input  pipe_ctrl_pkg::id_ex_bundle_t  ex_bundle,
        output logic [rv_isa_pkg::xlen-1:0]   alu_result
);

        import rv_isa_pkg::*;
        import pipe_ctrl_pkg::*;

        alu_ctrl_t          ctrl;
        word_t              op1;
        word_t              op2;
        logic [shamt_w-1:0] shamt;
        logic               lt_s;
        logic               lt_u;

        assign ctrl = ex_bundle.alu_ctrl;

        // ==============================
        // operand select
        // ==============================

        // choices are one-hot, so an and-or mux is enough
        assign op1 = ({xlen{ctrl.i1_rs1}} & ex_bundle.rs1_data)
                   | ({xlen{ctrl.i1_pc}}  & ex_bundle.pc);

        assign op2 = ({xlen{ctrl.i2_rs2}} & ex_bundle.rs2_data)
                   | ({xlen{ctrl.i2_imm}} & ex_bundle.imm)
                   | ({xlen{ctrl.i2_4}}   & word_t'(4))
                   | ({xlen{ctrl.i2_csr}} & ex_bundle.csr_rs_data);

        assign shamt = op2[shamt_w-1:0];

        // set-less-than flavours
        assign lt_s = $signed(op1) < $signed(op2);
        assign lt_u = op1 < op2;

        // ==============================
        // operation
        // ==============================

        always_comb begin
                alu_result = ({xlen{ctrl.op_add}}  & (op1 + op2))
                           | ({xlen{ctrl.op_sub}}  & (op1 - op2))
                           | ({xlen{ctrl.op_slt}}  & word_t'(lt_s))
                           | ({xlen{ctrl.op_sltu}} & word_t'(lt_u))
                           | ({xlen{ctrl.op_or}}   & (op1 | op2))
                           | ({xlen{ctrl.op_and}}  & (op1 & op2))
                           | ({xlen{ctrl.op_xor}}  & (op1 ^ op2))
                           | ({xlen{ctrl.op_sll}}  & (op1 << shamt))
                           | ({xlen{ctrl.op_srl}}  & (op1 >> shamt))
                           | ({xlen{ctrl.op_sra}}  & word_t'($signed(op1) >>> shamt));
        end

        // decode hands over at most one operation and one source per operand
        always_comb begin
                if (ex_bundle.op_valid) begin
                        a_alu_onehot : assert final (
                                $onehot0({ctrl.op_add, ctrl.op_sub, ctrl.op_slt, ctrl.op_sltu,
                                          ctrl.op_or, ctrl.op_and, ctrl.op_xor, ctrl.op_sll,
                                          ctrl.op_srl, ctrl.op_sra})
                                && $onehot({ctrl.i1_rs1, ctrl.i1_pc})
                                && $onehot({ctrl.i2_rs2, ctrl.i2_imm, ctrl.i2_4, ctrl.i2_csr}))
                                else $error("alu strobes or operand choice not one-hot");
                end
        end

endmodule

// ==== execute/branch_unit.sv ====
/*
 * Branch unit
 *
 * Compares rs1 against rs2 for the conditional branches and forms
 * the jump target from pc, rs1 or the csr value plus the immediate.
 */

`timescale 1ns/1ps

module branch_unit (
        input  pipe_ctrl_pkg::id_ex_bundle_t  ex_bundle,
        output pipe_ctrl_pkg::redirect_t      br_redirect
);

        import rv_isa_pkg::*;
        import pipe_ctrl_pkg::*;

        jump_ctrl_t ctrl;
        logic       eq;
        logic       lt_s;
        logic       ge_s;
        logic       cond_hit;
        word_t      tgt_pc;
        word_t      tgt_rs1;
        word_t      tgt_csr;

        assign ctrl = ex_bundle.jump_ctrl;

        // ==============================
        // compare
        // ==============================

        assign eq   = ex_bundle.rs1_data == ex_bundle.rs2_data;
        assign lt_s = $signed(ex_bundle.rs1_data) < $signed(ex_bundle.rs2_data);
        assign ge_s = ~lt_s;

        // beq, bne, bge, blt
        assign cond_hit = (ctrl.cmp_eq  & eq)
                        | (ctrl.cmp_neq & ~eq)
                        | (ctrl.cmp_ge  & ge_s)
                        | (ctrl.cmp_lt  & lt_s);

        // ==============================
        // target
        // ==============================

        assign tgt_pc  = ex_bundle.pc + ex_bundle.imm;

        // jalr drops the low bit
        assign tgt_rs1 = (ex_bundle.rs1_data + ex_bundle.imm) & ~word_t'(1);

        // trap return path, csr holds the vector or return address
        assign tgt_csr = ex_bundle.csr_rs_data + ex_bundle.imm;

        assign br_redirect.target = ({xlen{ctrl.pc_plus_imm}}  & tgt_pc)
                                  | ({xlen{ctrl.rs1_plus_imm}} & tgt_rs1)
                                  | ({xlen{ctrl.csr_plus_imm}} & tgt_csr);

        // op_valid gating happens in the merge
        assign br_redirect.taken = ctrl.jump | cond_hit;

endmodule

// ==== execute/exu_merge.sv ====
/*
 * Execute result merge
 *
 * Builds the execute result for memory and write-back from the
 * registered bundle, the ALU word and the branch redirect, and
 * qualifies every write enable and the redirect with op_valid.
 */

`timescale 1ns/1ps

module exu_merge (
        input  pipe_ctrl_pkg::id_ex_bundle_t  ex_bundle,
        input  logic [rv_isa_pkg::xlen-1:0]   alu_result,
        input  pipe_ctrl_pkg::redirect_t      br_redirect,
        output pipe_ctrl_pkg::ex_result_t     ex_result,
        output pipe_ctrl_pkg::redirect_t      redirect
);

        import pipe_ctrl_pkg::*;

        wb_ctrl_t  wb;
        mem_ctrl_t mem;
        logic      vld;
        logic      csr_op;

        assign wb     = ex_bundle.wb_ctrl;
        assign mem    = ex_bundle.mem_ctrl;
        assign vld    = ex_bundle.op_valid;
        assign csr_op = wb.csrrw | wb.csrrs;

        // ==============================
        // result
        // ==============================

        always_comb begin
                ex_result.op_valid   = vld;
                ex_result.pc         = ex_bundle.pc;
                ex_result.rd         = ex_bundle.rd;

                // csr instructions return the old csr value
                ex_result.wb_data    = csr_op ? ex_bundle.csr_rs_data : alu_result;
                ex_result.write_gpr  = wb.write_gpr & vld;

                // csrrs sets bits, csrrw replaces
                ex_result.write_csr  = wb.write_csr & vld;
                ex_result.csr_wdata  = wb.csrrs ? (ex_bundle.rs1_data | ex_bundle.csr_rs_data)
                                                : ex_bundle.rs1_data;

                // load and store address comes out of the adder
                ex_result.mem_to_reg = wb.mem_to_reg;
                ex_result.mem_addr   = alu_result;
                ex_result.store_data = ex_bundle.rs2_data;
                ex_result.mem_ctrl   = mem;
                ex_result.mem_ctrl.write_mem = mem.write_mem & vld;

                ex_result.ecall      = wb.ecall;
                ex_result.halt       = ex_bundle.system_halt;
        end

        // ==============================
        // redirect
        // ==============================

        assign redirect.taken  = br_redirect.taken & vld;
        assign redirect.target = br_redirect.target;

        // decode never marks a store as writing rd
        always_comb begin
                if (vld) begin
                        a_store_no_wb : assert final (!(mem.write_mem && wb.write_gpr))
                                else $error("store with register write");
                end
        end

endmodule

// ==== src/exu_stage_top.sv ====
/*
 * Execute stage top
 *
 * Segment register followed by the ALU and branch unit working in
 * parallel on the registered instruction, and the result merge.
 */

`timescale 1ns/1ps

module exu_stage_top (
        input  logic                          clk,
        input  logic                          rst,
        input  logic                          in_valid,
        input  logic                          exu_ready,
        input  logic                          flush,
        input  logic                          stall,
        input  pipe_ctrl_pkg::id_ex_bundle_t  in_bundle,
        output pipe_ctrl_pkg::ex_result_t     ex_result,
        output pipe_ctrl_pkg::redirect_t      redirect
);

        import rv_isa_pkg::*;
        import pipe_ctrl_pkg::*;

        id_ex_bundle_t   ex_bundle;
        logic [xlen-1:0] alu_result;
        redirect_t       br_redirect;

        // ==============================
        // pipeline register
        // ==============================

        id_ex_seg_reg u_seg_reg (
                .clk       (clk),
                .rst       (rst),
                .in_valid  (in_valid),
                .exu_ready (exu_ready),
                .flush     (flush),
                .stall     (stall),
                .in_bundle (in_bundle),
                .ex_bundle (ex_bundle)
        );

        // ==============================
        // execute
        // ==============================

        alu_unit u_alu (
                .ex_bundle  (ex_bundle),
                .alu_result (alu_result)
        );

        branch_unit u_branch (
                .ex_bundle   (ex_bundle),
                .br_redirect (br_redirect)
        );

        exu_merge u_merge (
                .ex_bundle   (ex_bundle),
                .alu_result  (alu_result),
                .br_redirect (br_redirect),
                .ex_result   (ex_result),
                .redirect    (redirect)
        );

endmodule

// ==== verif/tb_exu_vectors.svh ====
/*
 * Directed execute vectors
 *
 * One call per instruction: name, alu op and operand choices, jump,
 * write-back and memory controls, then pc, imm, rs1, rs2, csr data,
 * expected wb_data, csr_wdata, taken and target.
 */

`ifndef TB_EXU_VECTORS_SVH
`define TB_EXU_VECTORS_SVH

// jump_ctrl: jump, pc_plus_imm, rs1_plus_imm, csr_plus_imm, eq, neq, ge, lt
localparam jump_ctrl_t jc_none = 8'b0000_0000;
localparam jump_ctrl_t jc_beq  = 8'b0100_1000;
localparam jump_ctrl_t jc_bne  = 8'b0100_0100;
localparam jump_ctrl_t jc_bge  = 8'b0100_0010;
localparam jump_ctrl_t jc_blt  = 8'b0100_0001;
localparam jump_ctrl_t jc_jalr = 8'b1010_0000;
localparam jump_ctrl_t jc_csr  = 8'b1001_0000;

// wb_ctrl: write_gpr, write_csr, mem_to_reg, csrrs, csrrw, ecall
localparam wb_ctrl_t wc_none  = 6'b000000;
localparam wb_ctrl_t wc_gpr   = 6'b100000;
localparam wb_ctrl_t wc_csrrw = 6'b110010;
localparam wb_ctrl_t wc_csrrs = 6'b110100;
localparam wb_ctrl_t wc_load  = 6'b101000;
localparam wb_ctrl_t wc_ecall = 6'b000001;

// mem_ctrl: write_mem, byte, half, word, byte_u, half_u
localparam mem_ctrl_t mc_none = 6'b000000;
localparam mem_ctrl_t mc_sw   = 6'b100100;
localparam mem_ctrl_t mc_lw   = 6'b000100;

task automatic fill_vectors();
        add_vec("add_rs1_rs2", make_alu(op_add, s1_rs1, s2_rs2), jc_none, wc_gpr, mc_none,
                32'h100, 32'h0, 32'h5, 32'h7, 32'h0, 32'hc, 32'h5, 1'b0, 32'h0);
        add_vec("add_pc_imm", make_alu(op_add, s1_pc, s2_imm), jc_none, wc_gpr, mc_none,
                32'h100, 32'h20, 32'h0, 32'h0, 32'h0, 32'h120, 32'h0, 1'b0, 32'h0);
        add_vec("sub_rs1_4", make_alu(op_sub, s1_rs1, s2_4), jc_none, wc_gpr, mc_none,
                32'h100, 32'h0, 32'ha, 32'h0, 32'h0, 32'h6, 32'ha, 1'b0, 32'h0);
        add_vec("or_rs1_csr", make_alu(op_or, s1_rs1, s2_csr), jc_none, wc_gpr, mc_none,
                32'h100, 32'h0, 32'hf0, 32'h0, 32'h0f, 32'hff, 32'hf0, 1'b0, 32'h0);
        add_vec("and_rs1_imm", make_alu(op_and, s1_rs1, s2_imm), jc_none, wc_gpr, mc_none,
                32'h100, 32'h0f0f0f0f, 32'hff00ff00, 32'h0, 32'h0, 32'h0f000f00,
                32'hff00ff00, 1'b0, 32'h0);
        add_vec("xor_rs1_rs2", make_alu(op_xor, s1_rs1, s2_rs2), jc_none, wc_gpr, mc_none,
                32'h100, 32'h0, 32'haaaa5555, 32'hffff0000, 32'h0, 32'h55555555,
                32'haaaa5555, 1'b0, 32'h0);
        add_vec("slt_neg", make_alu(op_slt, s1_rs1, s2_rs2), jc_none, wc_gpr, mc_none,
                32'h100, 32'h0, 32'hffffffff, 32'h1, 32'h0, 32'h1, 32'hffffffff, 1'b0, 32'h0);
        add_vec("sltu_neg", make_alu(op_sltu, s1_rs1, s2_rs2), jc_none, wc_gpr, mc_none,
                32'h100, 32'h0, 32'hffffffff, 32'h1, 32'h0, 32'h0, 32'hffffffff, 1'b0, 32'h0);
        add_vec("sll_low5", make_alu(op_sll, s1_rs1, s2_rs2), jc_none, wc_gpr, mc_none,
                32'h100, 32'h0, 32'h1, 32'h23, 32'h0, 32'h8, 32'h1, 1'b0, 32'h0);
        add_vec("srl_31", make_alu(op_srl, s1_rs1, s2_imm), jc_none, wc_gpr, mc_none,
                32'h100, 32'd31, 32'h80000000, 32'h0, 32'h0, 32'h1, 32'h80000000, 1'b0, 32'h0);
        add_vec("sra_4", make_alu(op_sra, s1_rs1, s2_imm), jc_none, wc_gpr, mc_none,
                32'h100, 32'd4, 32'h80000000, 32'h0, 32'h0, 32'hf8000000,
                32'h80000000, 1'b0, 32'h0);
        add_vec("beq_taken", make_alu(op_none, s1_rs1, s2_rs2), jc_beq, wc_none, mc_none,
                32'h200, 32'h40, 32'h3, 32'h3, 32'h0, 32'h0, 32'h3, 1'b1, 32'h240);
        add_vec("bne_not_taken", make_alu(op_none, s1_rs1, s2_rs2), jc_bne, wc_none, mc_none,
                32'h200, 32'h40, 32'h3, 32'h3, 32'h0, 32'h0, 32'h3, 1'b0, 32'h240);
        add_vec("blt_taken", make_alu(op_none, s1_rs1, s2_rs2), jc_blt, wc_none, mc_none,
                32'h300, 32'hfffffff0, 32'hfffffffe, 32'h1, 32'h0, 32'h0, 32'hfffffffe,
                1'b1, 32'h2f0);
        add_vec("bge_not_taken", make_alu(op_none, s1_rs1, s2_rs2), jc_bge, wc_none, mc_none,
                32'h300, 32'hfffffff0, 32'hfffffffe, 32'h1, 32'h0, 32'h0, 32'hfffffffe,
                1'b0, 32'h2f0);
        add_vec("jalr_bit0", make_alu(op_add, s1_pc, s2_4), jc_jalr, wc_gpr, mc_none,
                32'h400, 32'h4, 32'h1001, 32'h0, 32'h0, 32'h404, 32'h1001, 1'b1, 32'h1004);
        add_vec("csr_jump", make_alu(op_none, s1_rs1, s2_rs2), jc_csr, wc_none, mc_none,
                32'h100, 32'h8, 32'h0, 32'h0, 32'h3000, 32'h0, 32'h0, 1'b1, 32'h3008);
        add_vec("csrrw", make_alu(op_none, s1_rs1, s2_rs2), jc_none, wc_csrrw, mc_none,
                32'h100, 32'h0, 32'h12, 32'h0, 32'h30, 32'h30, 32'h12, 1'b0, 32'h0);
        add_vec("csrrs", make_alu(op_none, s1_rs1, s2_rs2), jc_none, wc_csrrs, mc_none,
                32'h100, 32'h0, 32'h0f, 32'h0, 32'h30, 32'h30, 32'h3f, 1'b0, 32'h0);
        add_vec("store_word", make_alu(op_add, s1_rs1, s2_imm), jc_none, wc_none, mc_sw,
                32'h100, 32'h8, 32'h1000, 32'hdeadbeef, 32'h0, 32'h1008, 32'h1000, 1'b0, 32'h0);
        add_vec("load_word", make_alu(op_add, s1_rs1, s2_imm), jc_none, wc_load, mc_lw,
                32'h100, 32'h10, 32'h2000, 32'h0, 32'h0, 32'h2010, 32'h2000, 1'b0, 32'h0);
        add_vec("ecall", make_alu(op_none, s1_rs1, s2_rs2), jc_none, wc_ecall, mc_none,
                32'h100, 32'h0, 32'h0, 32'h0, 32'h0, 32'h0, 32'h0, 1'b0, 32'h0);
endtask

`endif

// ==== verif/tb_exu_stage.sv ====
/*
 * Execute stage testbench
 *
 * Runs a directed table, a random ALU phase and hold/flush checks
 * against the execute stage top, with a cycle limit.
 */

`timescale 1ns/1ps

module tb_exu_stage;

        import rv_isa_pkg::*;
        import pipe_ctrl_pkg::*;

        localparam int op_add = 0;
        localparam int op_sub = 1;
        localparam int op_slt = 2;
        localparam int op_sltu = 3;
        localparam int op_or = 4;
        localparam int op_and = 5;
        localparam int op_xor = 6;
        localparam int op_sll = 7;
        localparam int op_srl = 8;
        localparam int op_sra = 9;
        localparam int op_none = 10;
        localparam int s1_rs1 = 0;
        localparam int s1_pc = 1;
        localparam int s2_rs2 = 0;
        localparam int s2_imm = 1;
        localparam int s2_4 = 2;
        localparam int s2_csr = 3;
        localparam int reset_cycles = 10;
        localparam int num_rand = 40;
        localparam int hold_cycles = 8;

        typedef struct {
                string      name;
                alu_ctrl_t  alu;
                jump_ctrl_t jmp;
                wb_ctrl_t   wb;
                mem_ctrl_t  mem;
                word_t      pc;
                word_t      imm;
                word_t      rs1;
                word_t      rs2;
                word_t      csr;
                word_t      exp_wb;
                word_t      exp_csrw;
                logic       exp_taken;
                word_t      exp_target;
        } vec_t;

        logic          clk = 0;
        logic          rst;
        logic          in_valid;
        logic          exu_ready;
        logic          flush;
        logic          stall;
        id_ex_bundle_t in_bundle;
        ex_result_t    ex_result;
        redirect_t     redirect;

        vec_t vectors[$];
        int   err_count = 0;
        int   test_count = 0;
        int   fail_tests = 0;
        int   cycles = 0;
        int   cycle_limit = 1000000;

        exu_stage_top dut (
                .clk(clk), .rst(rst), .in_valid(in_valid), .exu_ready(exu_ready),
                .flush(flush), .stall(stall), .in_bundle(in_bundle),
                .ex_result(ex_result), .redirect(redirect)
        );

        always #2 clk = ~clk;

        // run limit
        always @(posedge clk) begin
                cycles++;
                if (cycles > cycle_limit) begin
                        $display("timeout: no finish after %0d cycles", cycles);
                        $display("Regression failed");
                        $finish;
                end
        end

        function automatic alu_ctrl_t make_alu(int op, int s1, int s2);
                alu_ctrl_t c;
                c = '0;
                case (op)
                        op_add:  c.op_add = 1'b1;
                        op_sub:  c.op_sub = 1'b1;
                        op_slt:  c.op_slt = 1'b1;
                        op_sltu: c.op_sltu = 1'b1;
                        op_or:   c.op_or = 1'b1;
                        op_and:  c.op_and = 1'b1;
                        op_xor:  c.op_xor = 1'b1;
                        op_sll:  c.op_sll = 1'b1;
                        op_srl:  c.op_srl = 1'b1;
                        op_sra:  c.op_sra = 1'b1;
                        default: ;
                endcase
                if (s1 == s1_pc) begin
                        c.i1_pc = 1'b1;
                end else begin
                        c.i1_rs1 = 1'b1;
                end
                case (s2)
                        s2_imm:  c.i2_imm = 1'b1;
                        s2_4:    c.i2_4 = 1'b1;
                        s2_csr:  c.i2_csr = 1'b1;
                        default: c.i2_rs2 = 1'b1;
                endcase
                return c;
        endfunction

        // reference alu for the random phase
        function automatic word_t alu_model(int op, word_t a, word_t b);
                case (op)
                        op_add:  return a + b;
                        op_sub:  return a - b;
                        op_slt:  return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
                        op_sltu: return (a < b) ? 32'd1 : 32'd0;
                        op_or:   return a | b;
                        op_and:  return a & b;
                        op_xor:  return a ^ b;
                        op_sll:  return a << b[4:0];
                        op_srl:  return a >> b[4:0];
                        op_sra:  return word_t'($signed(a) >>> b[4:0]);
                        default: return 32'd0;
                endcase
        endfunction

        task automatic add_vec(input string name, input alu_ctrl_t alu, input jump_ctrl_t jmp,
                               input wb_ctrl_t wb, input mem_ctrl_t mem, input word_t pc,
                               input word_t imm, input word_t rs1, input word_t rs2,
                               input word_t csr, input word_t exp_wb, input word_t exp_csrw,
                               input logic taken, input word_t target);
                vec_t v;
                v = '{name, alu, jmp, wb, mem, pc, imm, rs1, rs2, csr, exp_wb, exp_csrw,
                      taken, target};
                vectors.push_back(v);
        endtask

        `include "tb_exu_vectors.svh"

        task automatic check(input string name, input word_t expected, input word_t actual);
                if (expected !== actual) begin
                        $display("error %s: expected %h, actual %h", name, expected, actual);
                        err_count++;
                end
        endtask

        task automatic report(input string name, input int errs_before);
                test_count++;
                if (err_count == errs_before) begin
                        $display("test %s: ok", name);
                end else begin
                        $display("test %s: mismatch", name);
                        fail_tests++;
                end
        endtask

        task automatic drive_bundle(input vec_t v);
                id_ex_bundle_t b;
                b = '0;
                b.pc = v.pc;
                b.rd = 5'd1;
                b.imm = v.imm;
                b.rs1_data = v.rs1;
                b.rs2_data = v.rs2;
                b.csr_rs_data = v.csr;
                b.alu_ctrl = v.alu;
                b.jump_ctrl = v.jmp;
                b.wb_ctrl = v.wb;
                b.mem_ctrl = v.mem;
                // an ecall also stops the core
                b.system_halt = v.wb.ecall;
                b.op_valid = 1'b1;
                in_bundle = b;
        endtask

        // drive on a falling edge and sample on the next one
        task automatic run_vector(input vec_t v);
                int errs;
                errs = err_count;
                drive_bundle(v);
                in_valid = 1'b1;
                @(negedge clk);
                in_valid = 1'b0;
                check({v.name, " op_valid"}, 32'd1, word_t'(ex_result.op_valid));
                check({v.name, " pc"}, v.pc, ex_result.pc);
                check({v.name, " rd"}, 32'd1, word_t'(ex_result.rd));
                check({v.name, " wb_data"}, v.exp_wb, ex_result.wb_data);
                check({v.name, " csr_wdata"}, v.exp_csrw, ex_result.csr_wdata);
                check({v.name, " taken"}, word_t'(v.exp_taken), word_t'(redirect.taken));
                check({v.name, " target"}, v.exp_target, redirect.target);
                check({v.name, " write_gpr"}, word_t'(v.wb.write_gpr),
                      word_t'(ex_result.write_gpr));
                check({v.name, " write_csr"}, word_t'(v.wb.write_csr),
                      word_t'(ex_result.write_csr));
                check({v.name, " mem_to_reg"}, word_t'(v.wb.mem_to_reg),
                      word_t'(ex_result.mem_to_reg));
                check({v.name, " mem_ctrl"}, word_t'(v.mem), word_t'(ex_result.mem_ctrl));
                check({v.name, " ecall"}, word_t'(v.wb.ecall), word_t'(ex_result.ecall));
                check({v.name, " halt"}, word_t'(v.wb.ecall), word_t'(ex_result.halt));
                if (v.mem.write_mem || v.wb.mem_to_reg) begin
                        check({v.name, " mem_addr"}, v.exp_wb, ex_result.mem_addr);
                end
                if (v.mem.write_mem) begin
                        check({v.name, " store_data"}, v.rs2, ex_result.store_data);
                end
                report(v.name, errs);
        endtask

        // ==============================
        // hold and flush
        // ==============================

        task automatic hold_tests();
                int errs;
                errs = err_count;
                run_vector(vectors[0]);
                drive_bundle(vectors[1]);
                in_valid = 1'b1;
                exu_ready = 1'b0;
                repeat (2) @(negedge clk);
                check("ready_low wb_data", vectors[0].exp_wb, ex_result.wb_data);
                exu_ready = 1'b1;
                stall = 1'b1;
                repeat (2) @(negedge clk);
                check("stall wb_data", vectors[0].exp_wb, ex_result.wb_data);
                // the new bundle stays offered so the flush has to win over the load
                flush = 1'b1;
                @(negedge clk);
                check("stalled_flush op_valid", 32'd1, word_t'(ex_result.op_valid));
                check("stalled_flush wb_data", vectors[0].exp_wb, ex_result.wb_data);
                stall = 1'b0;
                @(negedge clk);
                flush = 1'b0;
                in_valid = 1'b0;
                check("flush op_valid", 32'd0, word_t'(ex_result.op_valid));
                check("flush pc", pc_rst, ex_result.pc);
                check("flush write_gpr", 32'd0, word_t'(ex_result.write_gpr));
                report("hold_and_flush", errs);
        endtask

        initial begin
                vec_t v;
                int   op;
                int   errs;
                void'($urandom(15544));
                rst = 1'b1;
                in_valid = 1'b0;
                exu_ready = 1'b1;
                flush = 1'b0;
                stall = 1'b0;
                in_bundle = '0;
                fill_vectors();
                cycle_limit = 2 * (vectors.size() + num_rand + hold_cycles) + reset_cycles;
                repeat (reset_cycles) @(posedge clk);
                @(negedge clk);
                rst = 1'b0;
                errs = err_count;
                check("reset op_valid", 32'd0, word_t'(ex_result.op_valid));
                check("reset write_gpr", 32'd0, word_t'(ex_result.write_gpr));
                check("reset write_csr", 32'd0, word_t'(ex_result.write_csr));
                check("reset write_mem", 32'd0, word_t'(ex_result.mem_ctrl.write_mem));
                check("reset taken", 32'd0, word_t'(redirect.taken));
                check("reset pc", pc_rst, ex_result.pc);
                report("reset", errs);
                foreach (vectors[i]) begin
                        run_vector(vectors[i]);
                end
                for (int i = 0; i < num_rand; i++) begin
                        op = $urandom % 10;
                        v = vectors[0];
                        v.name = $sformatf("rand_%0d", i);
                        v.rs1 = $urandom;
                        v.rs2 = $urandom;
                        v.imm = $urandom;
                        v.alu = make_alu(op, s1_rs1, ($urandom % 2) ? s2_imm : s2_rs2);
                        v.exp_wb = alu_model(op, v.rs1, v.alu.i2_imm ? v.imm : v.rs2);
                        v.exp_csrw = v.rs1;
                        run_vector(v);
                end
                hold_tests();
                $display("tests %0d, failed %0d, mismatches %0d", test_count, fail_tests,
                         err_count);
                if (err_count == 0) begin
                        $display("Regression passed");
                end else begin
                        $display("Regression failed");
                end
                $finish;
        end

endmodule

// ==== exu_stage.f ====
+incdir+verif
common/rv_isa_pkg.sv
common/pipe_ctrl_pkg.sv
src/id_ex_seg_reg.sv
execute/alu_unit.sv
execute/branch_unit.sv
execute/exu_merge.sv
src/exu_stage_top.sv
verif/tb_exu_stage.sv
